// File: glb.sv
`timescale 1ns/1ps

module glb #(
    parameter int LANE_W = 8
) (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               wr_en_i,
    input  logic                               rd_en_i,
    input  logic [sa_pkg::ARRAY_N*LANE_W-1:0]  wdata_i,
    output logic [sa_pkg::ARRAY_N*LANE_W-1:0]  rdata_o,
    output logic [sa_pkg::ARRAY_N-1:0]         lane_valid_o,
    output logic [sa_pkg::ARRAY_N-1:0]         full_o,
    output logic [sa_pkg::ARRAY_N-1:0]         empty_o
);

    logic [sa_pkg::ARRAY_N-2:0] rd_sr;
    logic [sa_pkg::ARRAY_N-1:0] rd_lane;

    // Lane j sees the read strobe j cycles late, matching the array diagonal
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_sr <= '0;
        end else begin
            rd_sr <= {rd_sr[sa_pkg::ARRAY_N-3:0], rd_en_i};
        end
    end

    assign rd_lane = {rd_sr, rd_en_i};

    // Valid follows the read by one cycle, like the registered FIFO data
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lane_valid_o <= '0;
        end else begin
            lane_valid_o <= rd_lane & ~empty_o;
        end
    end

    for (genvar j = 0; j < sa_pkg::ARRAY_N; j++) begin : g_lane
        sync_fifo #(
            .DATA_WIDTH (LANE_W),
            .DEPTH      (sa_pkg::FIFO_DEPTH)
        ) fifo_i (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .wr_en_i (wr_en_i),
            .rd_en_i (rd_lane[j]),
            .wdata_i (wdata_i[j*LANE_W +: LANE_W]),
            .full_o  (full_o[j]),
            .empty_o (empty_o[j]),
            .rdata_o (rdata_o[j*LANE_W +: LANE_W])
        );
    end

endmodule

// File: list.f
sa_pkg.sv
sync_fifo.sv
glb.sv
mac_pe.sv
pe_array.sv
sa_top.sv
tb_sa_top.sv

// File: mac_pe.sv
`timescale 1ns/1ps

module mac_pe (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic signed [sa_pkg::DATA_W-1:0] w_i,
    input  logic                            w_load_i,
    output logic signed [sa_pkg::DATA_W-1:0] w_o,
    output logic                            w_load_o,
    input  logic signed [sa_pkg::DATA_W-1:0] act_i,
    input  logic                            act_valid_i,
    output logic signed [sa_pkg::DATA_W-1:0] act_o,
    output logic                            act_valid_o,
    input  logic signed [sa_pkg::ACC_W-1:0]  psum_i,
    output logic signed [sa_pkg::ACC_W-1:0]  psum_o,
    output logic                            psum_valid_o
);

    logic signed [2*sa_pkg::DATA_W-1:0] prod;

    // Whole column shifts together, so the load strobe passes straight down
    assign w_load_o = w_load_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            w_o <= '0;
        end else if (w_load_i) begin
            w_o <= w_i;
        end
    end

    assign prod = w_o * act_i;

    always_ff @(posedge clk) begin
        act_o <= act_i;
        if (act_valid_i) begin
            psum_o <= psum_i + {{(sa_pkg::ACC_W - 2*sa_pkg::DATA_W){prod[2*sa_pkg::DATA_W-1]}},
                                prod};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            act_valid_o  <= 1'b0;
            psum_valid_o <= 1'b0;
        end else begin
            act_valid_o  <= act_valid_i;
            psum_valid_o <= act_valid_i;
        end
    end

endmodule

// File: pe_array.sv
`timescale 1ns/1ps

module pe_array (
    input  logic                                       clk,
    input  logic                                       rst_n_i,
    input  logic [sa_pkg::ARRAY_N*sa_pkg::DATA_W-1:0]  w_col_i,
    input  logic [sa_pkg::ARRAY_N-1:0]                 w_load_i,
    input  logic [sa_pkg::ARRAY_N*sa_pkg::DATA_W-1:0]  act_row_i,
    input  logic [sa_pkg::ARRAY_N-1:0]                 act_valid_i,
    output logic [sa_pkg::ARRAY_N*sa_pkg::ACC_W-1:0]   psum_o,
    output logic [sa_pkg::ARRAY_N-1:0]                 psum_valid_o
);

    // Each array element holds the output of the PE at [row][col]
    logic [sa_pkg::DATA_W-1:0] w_q      [sa_pkg::ARRAY_N][sa_pkg::ARRAY_N];
    logic                      w_load_q [sa_pkg::ARRAY_N][sa_pkg::ARRAY_N];
    logic [sa_pkg::DATA_W-1:0] act_q    [sa_pkg::ARRAY_N][sa_pkg::ARRAY_N];
    logic                      act_v_q  [sa_pkg::ARRAY_N][sa_pkg::ARRAY_N];
    logic [sa_pkg::ACC_W-1:0]  psum_q   [sa_pkg::ARRAY_N][sa_pkg::ARRAY_N];
    logic                      psum_v_q [sa_pkg::ARRAY_N][sa_pkg::ARRAY_N];

    for (genvar r = 0; r < sa_pkg::ARRAY_N; r++) begin : g_row
        for (genvar c = 0; c < sa_pkg::ARRAY_N; c++) begin : g_col
            logic [sa_pkg::DATA_W-1:0] w_in;
            logic                      w_load_in;
            logic [sa_pkg::DATA_W-1:0] act_in;
            logic                      act_v_in;
            logic [sa_pkg::ACC_W-1:0]  psum_in;

            // Weights and partial sums enter at the top, activations at the left
            assign w_in      = (r == 0) ? w_col_i[c*sa_pkg::DATA_W +: sa_pkg::DATA_W]
                                        : w_q[(r == 0) ? 0 : r-1][c];
            assign w_load_in = (r == 0) ? w_load_i[c] : w_load_q[(r == 0) ? 0 : r-1][c];
            assign psum_in   = (r == 0) ? '0 : psum_q[(r == 0) ? 0 : r-1][c];
            assign act_in    = (c == 0) ? act_row_i[r*sa_pkg::DATA_W +: sa_pkg::DATA_W]
                                        : act_q[r][(c == 0) ? 0 : c-1];
            assign act_v_in  = (c == 0) ? act_valid_i[r] : act_v_q[r][(c == 0) ? 0 : c-1];

            mac_pe pe_i (
                .clk          (clk),
                .rst_n_i      (rst_n_i),
                .w_i          (w_in),
                .w_load_i     (w_load_in),
                .w_o          (w_q[r][c]),
                .w_load_o     (w_load_q[r][c]),
                .act_i        (act_in),
                .act_valid_i  (act_v_in),
                .act_o        (act_q[r][c]),
                .act_valid_o  (act_v_q[r][c]),
                .psum_i       (psum_in),
                .psum_o       (psum_q[r][c]),
                .psum_valid_o (psum_v_q[r][c])
            );
        end
    end

    for (genvar c = 0; c < sa_pkg::ARRAY_N; c++) begin : g_out
        assign psum_o[c*sa_pkg::ACC_W +: sa_pkg::ACC_W] = psum_q[sa_pkg::ARRAY_N-1][c];
        assign psum_valid_o[c] = psum_v_q[sa_pkg::ARRAY_N-1][c];
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the systolic array testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module tb_sa_top -f list.f \
    && ./obj_dir/Vtb_sa_top \
    || exit 1

// File: sa_pkg.sv
package sa_pkg;

    // Array is ARRAY_N by ARRAY_N processing elements
    localparam int ARRAY_N = 4;

    // Signed weight and activation width
    localparam int DATA_W = 8;

    // Partial sum width covers four 16-bit products plus headroom
    localparam int ACC_W = 20;

    // Lane FIFO geometry
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = 4;

endpackage

// File: sa_top.sv
`timescale 1ns/1ps

module sa_top (
    input  logic                                       clk,
    input  logic                                       rst_n_i,
    input  logic                                       w_wr_i,
    input  logic                                       w_rd_i,
    input  logic [sa_pkg::ARRAY_N*sa_pkg::DATA_W-1:0]  w_wdata_i,
    output logic [sa_pkg::ARRAY_N-1:0]                 w_full_o,
    output logic [sa_pkg::ARRAY_N-1:0]                 w_empty_o,
    input  logic                                       a_wr_i,
    input  logic                                       a_rd_i,
    input  logic [sa_pkg::ARRAY_N*sa_pkg::DATA_W-1:0]  a_wdata_i,
    output logic [sa_pkg::ARRAY_N-1:0]                 a_full_o,
    output logic [sa_pkg::ARRAY_N-1:0]                 a_empty_o,
    output logic [sa_pkg::ARRAY_N*sa_pkg::ACC_W-1:0]   result_o,
    output logic [sa_pkg::ARRAY_N-1:0]                 result_valid_o
);

    logic [sa_pkg::ARRAY_N*sa_pkg::DATA_W-1:0] w_col;
    logic [sa_pkg::ARRAY_N-1:0]                w_load;
    logic [sa_pkg::ARRAY_N*sa_pkg::DATA_W-1:0] act_row;
    logic [sa_pkg::ARRAY_N-1:0]                act_valid;

    // Weight lanes feed columns
    glb #(
        .LANE_W (sa_pkg::DATA_W)
    ) weight_glb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wr_en_i      (w_wr_i),
        .rd_en_i      (w_rd_i),
        .wdata_i      (w_wdata_i),
        .rdata_o      (w_col),
        .lane_valid_o (w_load),
        .full_o       (w_full_o),
        .empty_o      (w_empty_o)
    );

    // Activation lanes feed rows
    glb #(
        .LANE_W (sa_pkg::DATA_W)
    ) act_glb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wr_en_i      (a_wr_i),
        .rd_en_i      (a_rd_i),
        .wdata_i      (a_wdata_i),
        .rdata_o      (act_row),
        .lane_valid_o (act_valid),
        .full_o       (a_full_o),
        .empty_o      (a_empty_o)
    );

    pe_array pe_array_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .w_col_i      (w_col),
        .w_load_i     (w_load),
        .act_row_i    (act_row),
        .act_valid_i  (act_valid),
        .psum_o       (result_o),
        .psum_valid_o (result_valid_o)
    );

endmodule

// File: sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  wr_en_i,
    input  logic                  rd_en_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic                  full_o,
    output logic                  empty_o,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    logic [DATA_WIDTH-1:0]      mem [DEPTH];
    logic [sa_pkg::FIFO_AW-1:0] wr_ptr;
    logic [sa_pkg::FIFO_AW-1:0] rd_ptr;
    logic [sa_pkg::FIFO_AW:0]   count;
    logic                       do_wr;
    logic                       do_rd;

    assign full_o  = (count == (sa_pkg::FIFO_AW + 1)'(DEPTH));
    assign empty_o = (count == '0);

    // Overflow and underflow requests are dropped
    assign do_wr = wr_en_i & ~full_o;
    assign do_rd = rd_en_i & ~empty_o;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata_i;
        end
        if (do_rd) begin
            rdata_o <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == (sa_pkg::FIFO_AW)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == (sa_pkg::FIFO_AW)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: tb_sa_top.sv
`timescale 1ns/1ps

module tb_sa_top;

    localparam int N = sa_pkg::ARRAY_N;
    localparam int WORD_W = sa_pkg::ARRAY_N * sa_pkg::DATA_W;
    localparam int NUM_CASES = 5;
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    // Fill case needs two full FIFO passes plus load and drain latency
    localparam int CASE_BUDGET = 4 * sa_pkg::FIFO_DEPTH + 8 * N + 20;

    logic                            clk;
    logic                            rst_n_i;
    logic                            w_wr;
    logic                            w_rd;
    logic [WORD_W-1:0]               w_wdata;
    logic [N-1:0]                    w_full;
    logic [N-1:0]                    w_empty;
    logic                            a_wr;
    logic                            a_rd;
    logic [WORD_W-1:0]               a_wdata;
    logic [N-1:0]                    a_full;
    logic [N-1:0]                    a_empty;
    logic [N*sa_pkg::ACC_W-1:0]      result;
    logic [N-1:0]                    result_valid;

    // Weight rows keep column c in byte c and activation words keep row r in byte r
    logic [WORD_W-1:0]               w_rows  [NUM_CASES][N];
    logic [WORD_W-1:0]               a_words [NUM_CASES][sa_pkg::FIFO_DEPTH];
    int                              nvec    [NUM_CASES];
    bit                              rand_en [NUM_CASES];
    bit                              fill_en [NUM_CASES];

    logic signed [sa_pkg::ACC_W-1:0] exp_q   [N][$];
    int                              seed;

    sa_top dut_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .w_wr_i         (w_wr),
        .w_rd_i         (w_rd),
        .w_wdata_i      (w_wdata),
        .w_full_o       (w_full),
        .w_empty_o      (w_empty),
        .a_wr_i         (a_wr),
        .a_rd_i         (a_rd),
        .a_wdata_i      (a_wdata),
        .a_full_o       (a_full),
        .a_empty_o      (a_empty),
        .result_o       (result),
        .result_valid_o (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int lane_value(input logic [WORD_W-1:0] word, input int j);
        return int'($signed(word[j*sa_pkg::DATA_W +: sa_pkg::DATA_W]));
    endfunction

    // Column c result is the sum over rows of activation[r] times weight[r][c]
    function automatic logic signed [sa_pkg::ACC_W-1:0] expected_sum(input int k, input int v,
                                                                     input int c);
        int sum;
        sum = 0;
        for (int r = 0; r < N; r++) begin
            sum += lane_value(a_words[k][v], r) * lane_value(w_rows[k][r], c);
        end
        return (sa_pkg::ACC_W)'(sum);
    endfunction

    function automatic int pending_results();
        int n;
        n = 0;
        for (int c = 0; c < N; c++) begin
            n += exp_q[c].size();
        end
        return n;
    endfunction

    task automatic build_table();
        // Identity weights return each vector unchanged
        w_rows[0][0] = 32'h0000_0001;
        w_rows[0][1] = 32'h0000_0100;
        w_rows[0][2] = 32'h0001_0000;
        w_rows[0][3] = 32'h0100_0000;
        a_words[0][0] = 32'h0403_0201;
        a_words[0][1] = 32'h08f9_06fb;
        a_words[0][2] = 32'hff00_807f;
        a_words[0][3] = 32'h281e_140a;
        nvec[0] = 4;
        // Signed extremes
        w_rows[1][0] = 32'h8080_8080;
        w_rows[1][1] = 32'h7f7f_7f7f;
        w_rows[1][2] = 32'h807f_807f;
        w_rows[1][3] = 32'h7f80_7f80;
        a_words[1][0] = 32'h8080_8080;
        a_words[1][1] = 32'h7f7f_7f7f;
        a_words[1][2] = 32'h807f_7f80;
        a_words[1][3] = 32'h7f80_807f;
        nvec[1] = 4;
        // Random back-to-back, then a reload, then a full-depth pass
        nvec[2] = 8;
        nvec[3] = 6;
        nvec[4] = sa_pkg::FIFO_DEPTH;
        for (int k = 0; k < NUM_CASES; k++) begin
            rand_en[k] = (k >= 2);
            fill_en[k] = (k == 4);
            if (rand_en[k]) begin
                for (int r = 0; r < N; r++) begin
                    w_rows[k][r] = $random(seed);
                end
                for (int v = 0; v < nvec[k]; v++) begin
                    a_words[k][v] = $random(seed);
                end
            end
        end
    endtask

    // Bottom row goes in first, so rows are written in reverse
    task automatic load_weights(input int k, input int reps);
        for (int i = 0; i < reps * N; i++) begin
            w_wdata = w_rows[k][N - 1 - (i % N)];
            w_wr = 1'b1;
            next_cycle();
        end
        w_wr = 1'b0;
        if (reps * N == sa_pkg::FIFO_DEPTH) begin
            assert (w_full == '1) else stop_on_error($sformatf(
                "mismatch at %0t: w_full_o got %b expected %b", $time, w_full, {N{1'b1}}));
            // This word hits full FIFOs and is dropped
            w_wdata = {N{8'h5a}};
            w_wr = 1'b1;
            next_cycle();
            w_wr = 1'b0;
        end
        w_rd = 1'b1;
        repeat (reps * N) next_cycle();
        w_rd = 1'b0;
        repeat (N + 1) next_cycle();
        assert (w_empty == '1) else stop_on_error($sformatf(
            "mismatch at %0t: w_empty_o got %b expected %b", $time, w_empty, {N{1'b1}}));
    endtask

    task automatic run_activations(input int k);
        for (int v = 0; v < nvec[k]; v++) begin
            a_wdata = a_words[k][v];
            a_wr = 1'b1;
            next_cycle();
        end
        a_wr = 1'b0;
        if (fill_en[k]) begin
            assert (a_full == '1) else stop_on_error($sformatf(
                "mismatch at %0t: a_full_o got %b expected %b", $time, a_full, {N{1'b1}}));
            a_wdata = {N{8'ha5}};
            a_wr = 1'b1;
            next_cycle();
            a_wr = 1'b0;
        end
        for (int v = 0; v < nvec[k]; v++) begin
            for (int c = 0; c < N; c++) begin
                exp_q[c].push_back(expected_sum(k, v, c));
            end
        end
        a_rd = 1'b1;
        repeat (nvec[k]) next_cycle();
        a_rd = 1'b0;
        while (pending_results() != 0) next_cycle();
        assert (a_empty == '1) else stop_on_error($sformatf(
            "mismatch at %0t: a_empty_o got %b expected %b", $time, a_empty, {N{1'b1}}));
        assert (result_valid == '0) else stop_on_error($sformatf(
            "mismatch at %0t: result_valid_o got %b expected %b", $time, result_valid, {N{1'b0}}));
    endtask

    // Results are sampled mid-cycle
    always @(negedge clk) begin
        logic signed [sa_pkg::ACC_W-1:0] got;
        logic signed [sa_pkg::ACC_W-1:0] want;
        if (rst_n_i) begin
            for (int c = 0; c < N; c++) begin
                if (result_valid[c]) begin
                    assert (exp_q[c].size() > 0) else stop_on_error($sformatf(
                        "unexpected result in column %0d at %0t", c, $time));
                    got = $signed(result[c*sa_pkg::ACC_W +: sa_pkg::ACC_W]);
                    want = exp_q[c].pop_front();
                    assert (got == want) else stop_on_error($sformatf(
                        "mismatch at %0t: result_o[%0d] got %0d expected %0d",
                        $time, c, got, want));
                end
            end
        end
    end

    initial begin
        #((RESET_CYCLES + NUM_CASES * CASE_BUDGET) * CLK_PERIOD);
        $display("timeout: results did not arrive in time");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 32'hdb63_8d85;
        rst_n_i = 1'b0;
        w_wr = 1'b0;
        w_rd = 1'b0;
        w_wdata = '0;
        a_wr = 1'b0;
        a_rd = 1'b0;
        a_wdata = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        assert (w_empty == '1) else stop_on_error($sformatf(
            "mismatch at %0t: w_empty_o got %b expected %b", $time, w_empty, {N{1'b1}}));
        assert (a_empty == '1) else stop_on_error($sformatf(
            "mismatch at %0t: a_empty_o got %b expected %b", $time, a_empty, {N{1'b1}}));
        assert (w_full == '0) else stop_on_error($sformatf(
            "mismatch at %0t: w_full_o got %b expected %b", $time, w_full, {N{1'b0}}));
        assert (a_full == '0) else stop_on_error($sformatf(
            "mismatch at %0t: a_full_o got %b expected %b", $time, a_full, {N{1'b0}}));
        assert (result_valid == '0) else stop_on_error($sformatf(
            "mismatch at %0t: result_valid_o got %b expected %b", $time, result_valid, {N{1'b0}}));
        rst_n_i = 1'b1;
        next_cycle();
        for (int k = 0; k < NUM_CASES; k++) begin
            load_weights(k, fill_en[k] ? sa_pkg::FIFO_DEPTH / N : 1);
            run_activations(k);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
